//--- common/cla_pkg.sv
package cla_pkg;

    // Datapath widths of the two-level lookahead adder.
    localparam int unsigned WORD_BITS  = 32; // Operand and result width.
    localparam int unsigned BLOCK_BITS = 4;  // Width of one first-level lookahead block.
    localparam int unsigned GROUP_BITS = 16; // Width of one second-level group of four blocks.

    // The status flags vector that travels with each result.
    localparam int unsigned FLAG_BITS = 4; // Carry, zero, negative and overflow.

    // Bit positions inside the flags vector.
    localparam int unsigned FLAG_CARRY    = 0; // Adder carry-out, for subtract 1 means no borrow.
    localparam int unsigned FLAG_ZERO     = 1; // Result is all zeros.
    localparam int unsigned FLAG_NEGATIVE = 2; // Copy of the result sign bit.
    localparam int unsigned FLAG_OVERFLOW = 3; // Signed two's-complement overflow.

endpackage

//--- cla/cla_block4.sv
`timescale 1ns/1ps

module cla_block4
    import cla_pkg::*;
(
    input  logic [BLOCK_BITS-1:0] a,               // First addend slice.
    input  logic [BLOCK_BITS-1:0] b,               // Second addend slice.
    input  logic                  carry_in,        // Carry into bit 0, formed by the parent.
    output logic [BLOCK_BITS-1:0] sum,             // Sum slice.
    output logic                  group_propagate, // Block passes an incoming carry through.
    output logic                  group_generate   // Block creates a carry on its own.
);

    logic [BLOCK_BITS-1:0] gen;   // Per-bit generate, both inputs high.
    logic [BLOCK_BITS-1:0] prop;  // Per-bit propagate, inputs differ.
    logic [BLOCK_BITS-1:0] carry; // Carry into each bit position.

    assign gen  = a & b;         // A bit pair of ones always makes a carry.
    assign prop = a ^ b;         // Exactly one one lets a lower carry pass.

    // Internal carries are written out flat so that none waits on its neighbour.
    assign carry[0] = carry_in;  // Bit 0 sees the parent carry directly.
    assign carry[1] = gen[0]
                    | (prop[0] & carry_in); // Carry from bit 0 or passed through it.
    assign carry[2] = gen[1]
                    | (prop[1] & gen[0])
                    | (prop[1] & prop[0] & carry_in); // Two-bit lookahead term.
    assign carry[3] = gen[2]
                    | (prop[2] & gen[1])
                    | (prop[2] & prop[1] & gen[0])
                    | (prop[2] & prop[1] & prop[0] & carry_in); // Three-bit lookahead term.

    assign sum = prop ^ carry;   // Half-sum combined with the carry into each bit.

    // Group terms let the level above decide the carry out of this block.
    assign group_propagate = &prop; // All four bits propagate.
    assign group_generate  = gen[3]
                           | (prop[3] & gen[2])
                           | (prop[3] & prop[2] & gen[1])
                           | (prop[3] & prop[2] & prop[1] & gen[0]); // Carry born inside block.

endmodule

//--- cla/cla_group16.sv
`timescale 1ns/1ps

module cla_group16
    import cla_pkg::*;
(
    input  logic [GROUP_BITS-1:0] a,               // First addend slice.
    input  logic [GROUP_BITS-1:0] b,               // Second addend slice.
    input  logic                  carry_in,        // Carry into the lowest block.
    output logic [GROUP_BITS-1:0] sum,             // Sum slice.
    output logic                  group_propagate, // Whole group passes a carry through.
    output logic                  group_generate   // Whole group creates a carry.
);

    localparam int unsigned NUM_BLOCKS = GROUP_BITS / BLOCK_BITS; // Four blocks per group.

    logic [NUM_BLOCKS-1:0] blk_prop;  // Group propagate reported by each block.
    logic [NUM_BLOCKS-1:0] blk_gen;   // Group generate reported by each block.
    logic [NUM_BLOCKS-1:0] blk_carry; // Carry handed into each block.

    // Second lookahead level, the carry into every block comes from block P/G only.
    assign blk_carry[0] = carry_in; // The lowest block takes the group carry unchanged.
    assign blk_carry[1] = blk_gen[0]
                        | (blk_prop[0] & carry_in); // Out of block 0.
    assign blk_carry[2] = blk_gen[1]
                        | (blk_prop[1] & blk_gen[0])
                        | (blk_prop[1] & blk_prop[0] & carry_in); // Out of blocks 0 and 1.
    assign blk_carry[3] = blk_gen[2]
                        | (blk_prop[2] & blk_gen[1])
                        | (blk_prop[2] & blk_prop[1] & blk_gen[0])
                        | (blk_prop[2] & blk_prop[1] & blk_prop[0] & carry_in); // Out of 0 to 2.

    // One block per four-bit slice, all fed in parallel.
    for (genvar i = 0; i < NUM_BLOCKS; i++) begin : g_block
        cla_block4 block (
            .a               (a[i*BLOCK_BITS +: BLOCK_BITS]),   // Slice of operand A.
            .b               (b[i*BLOCK_BITS +: BLOCK_BITS]),   // Slice of operand B.
            .carry_in        (blk_carry[i]),                    // Lookahead carry.
            .sum             (sum[i*BLOCK_BITS +: BLOCK_BITS]), // Slice of the sum.
            .group_propagate (blk_prop[i]),                     // Block propagate upward.
            .group_generate  (blk_gen[i])                       // Block generate upward.
        );
    end

    // Collapse the four block terms into one pair for the 32-bit level.
    assign group_propagate = &blk_prop; // Every block propagates.
    assign group_generate  = blk_gen[3]
                           | (blk_prop[3] & blk_gen[2])
                           | (blk_prop[3] & blk_prop[2] & blk_gen[1])
                           | (blk_prop[3] & blk_prop[2] & blk_prop[1] & blk_gen[0]); // Born here.

endmodule

//--- cla/cla_adder32.sv
`timescale 1ns/1ps

module cla_adder32
    import cla_pkg::*;
(
    input  logic [WORD_BITS-1:0] a,         // First addend.
    input  logic [WORD_BITS-1:0] b,         // Second addend.
    input  logic                 carry_in,  // Carry into bit 0.
    output logic [WORD_BITS-1:0] sum,       // Full-width sum.
    output logic                 carry_out  // Carry out of bit 31.
);

    logic lo_prop;  // Low group propagate.
    logic lo_gen;   // Low group generate.
    logic hi_prop;  // High group propagate.
    logic hi_gen;   // High group generate.
    logic hi_carry; // Carry handed into the high group.

    // The low group works on bits 15 to 0 and gets the external carry.
    cla_group16 group_lo (
        .a               (a[GROUP_BITS-1:0]),   // Lower half of A.
        .b               (b[GROUP_BITS-1:0]),   // Lower half of B.
        .carry_in        (carry_in),            // Straight from the caller.
        .sum             (sum[GROUP_BITS-1:0]), // Lower half of the sum.
        .group_propagate (lo_prop),
        .group_generate  (lo_gen)
    );

    // Top lookahead level, no ripple through the low group's bits.
    assign hi_carry = lo_gen | (lo_prop & carry_in); // Carry across the 16-bit boundary.

    // The high group works on bits 31 to 16.
    cla_group16 group_hi (
        .a               (a[WORD_BITS-1:GROUP_BITS]),   // Upper half of A.
        .b               (b[WORD_BITS-1:GROUP_BITS]),   // Upper half of B.
        .carry_in        (hi_carry),                    // Lookahead carry from below.
        .sum             (sum[WORD_BITS-1:GROUP_BITS]), // Upper half of the sum.
        .group_propagate (hi_prop),
        .group_generate  (hi_gen)
    );

    // Carry out of the word, again formed from group terms only.
    assign carry_out = hi_gen
                     | (hi_prop & lo_gen)
                     | (hi_prop & lo_prop & carry_in); // Two-group lookahead.

endmodule

//--- src/add_sub_unit.sv
`timescale 1ns/1ps

module add_sub_unit
    import cla_pkg::*;
(
    input  logic                 clk,       // Unit clock, all state on the rising edge.
    input  logic                 reset,     // Synchronous, active high.
    input  logic                 in_valid,  // Operands and subtract are valid this cycle.
    input  logic                 subtract,  // 1 selects A - B, 0 selects A + B.
    input  logic [WORD_BITS-1:0] operand_a, // First operand.
    input  logic [WORD_BITS-1:0] operand_b, // Second operand.
    output logic                 out_valid, // Result and flags belong to a new operation.
    output logic [WORD_BITS-1:0] result,    // Registered sum or difference.
    output logic [FLAG_BITS-1:0] flags      // Registered status flags.
);

    logic [WORD_BITS-1:0] operand_b_cond; // B as seen by the adder.
    logic [WORD_BITS-1:0] sum;            // Raw adder output.
    logic                 carry_out;      // Adder carry out of bit 31.
    logic                 sign_a;         // Sign of operand A.
    logic                 sign_b;         // Sign of the conditioned operand B.
    logic                 sign_sum;       // Sign of the raw sum.
    logic [FLAG_BITS-1:0] flags_next;     // Flags for the operation in flight.

    // Two's-complement subtract, A + ~B + 1, with the +1 entering as carry-in.
    assign operand_b_cond = subtract ? ~operand_b : operand_b; // Invert B for subtract.

    cla_adder32 adder0 (
        .a         (operand_a),      // A goes in unchanged.
        .b         (operand_b_cond), // Conditioned B.
        .carry_in  (subtract),       // Completes the negation of B.
        .sum       (sum),
        .carry_out (carry_out)
    );

    assign sign_a   = operand_a[WORD_BITS-1];      // A sign bit.
    assign sign_b   = operand_b_cond[WORD_BITS-1]; // Sign of what the adder actually adds.
    assign sign_sum = sum[WORD_BITS-1];            // Sign of the result.

    // Flags are decoded from the adder outputs before the register.
    always_comb begin
        flags_next                = '0;
        flags_next[FLAG_CARRY]    = carry_out;                              // No borrow on sub.
        flags_next[FLAG_ZERO]     = (sum == '0);                            // All result bits 0.
        flags_next[FLAG_NEGATIVE] = sign_sum;                               // Result is negative.
        flags_next[FLAG_OVERFLOW] = (sign_a == sign_b) && (sign_sum != sign_a); // Sign flipped.
    end

    // One pipeline stage, result and flags only move when an operation is taken.
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0; // No operation in flight after reset.
            result    <= '0;   // Known result out of reset.
            flags     <= '0;   // Known flags out of reset.
        end else begin
            out_valid <= in_valid; // Valid pulse trails the input strobe by one cycle.
            if (in_valid) begin
                result <= sum;        // Capture the new result.
                flags  <= flags_next; // Capture its flags with it.
            end
        end
    end

    // The registered result must equal plain modulo 2^32 arithmetic on the taken operands.
    a_result_matches: assert property (
        @(posedge clk) disable iff (reset)
        in_valid |=> result == $past(subtract ? operand_a - operand_b
                                              : operand_a + operand_b)
    ) else $error("add_sub_unit result differs from modulo 2^32 arithmetic on the operands");

    // out_valid is exactly the input strobe delayed by one clock.
    a_valid_latency: assert property (
        @(posedge clk)
        !reset |=> out_valid == $past(in_valid)
    ) else $error("add_sub_unit out_valid does not follow in_valid by one cycle");

    // Nothing leaves the unit in the cycle right after a reset.
    a_valid_after_reset: assert property (
        @(posedge clk)
        reset |=> !out_valid
    ) else $error("add_sub_unit out_valid high right after reset");

endmodule

//--- testbench/tb_add_sub_unit.sv
`timescale 1ns/1ps

module tb_add_sub_unit
    import cla_pkg::*;
();

    localparam int unsigned RESET_CYCLES = 5;    // Edges with reset held high.
    localparam int unsigned RANDOM_OPS   = 1000; // Back-to-back random operations.
    localparam int unsigned GAP_OPS      = 100;  // Random operations followed by idle cycles.
    localparam int unsigned MAX_GAP      = 3;    // Longest idle gap after one operation.
    // Reset, about 20 directed operations, the stream and GAP_OPS * (1 + MAX_GAP) cycles
    // come to under 1,450 cycles in the worst case.
    localparam int unsigned MAX_CYCLES   = 2500; // Limit with wide margin over that work.

    logic                 clk = 1'b0; // Free-running testbench clock.
    logic                 reset;
    logic                 in_valid;
    logic                 subtract;
    logic [WORD_BITS-1:0] operand_a;
    logic [WORD_BITS-1:0] operand_b;
    logic                 out_valid;
    logic [WORD_BITS-1:0] result;
    logic [FLAG_BITS-1:0] flags;

    logic [WORD_BITS-1:0] exp_result_q[$]; // Expected results in issue order.
    logic [FLAG_BITS-1:0] exp_flags_q[$];  // Expected flags in issue order.
    string                exp_name_q[$];   // Test name of each pending operation.

    logic                 in_valid_seen; // in_valid as the DUT sampled it at the last edge.
    logic [WORD_BITS-1:0] last_result;   // Value the result must hold between pulses.
    logic [FLAG_BITS-1:0] last_flags;    // Value the flags must hold between pulses.
    int unsigned          cycle_count;   // Rising edges seen so far.
    int                   seed;          // Seed for every $random call.
    logic [WORD_BITS-1:0] rnd_a;
    logic [WORD_BITS-1:0] rnd_b;
    logic [WORD_BITS-1:0] rnd_ctl;       // Random control bits for subtract, zero bias and gaps.

    add_sub_unit dut0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .subtract  (subtract),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .out_valid (out_valid),
        .result    (result),
        .flags     (flags)
    );

    always #5 clk = ~clk; // 10 ns period.

    // Prints the fail line and ends the run.
    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic compare_result(input string name, input logic [WORD_BITS-1:0] expected,
                                  input logic [WORD_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("** Error [%0s] result: expected 0x%08h, actual 0x%08h",
                     name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_flags(input string name, input logic [FLAG_BITS-1:0] expected,
                                 input logic [FLAG_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("** Error [%0s] flags (VNZC): expected %04b, actual %04b",
                     name, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_valid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error [%0s] out_valid: expected %0b, actual %0b", name, expected, actual);
            abort_run();
        end
    endtask

    // Flags vector built from the four named conditions.
    function automatic logic [FLAG_BITS-1:0] make_flags(input logic carry, input logic zero,
                                                         input logic negative, input logic ovf);
        logic [FLAG_BITS-1:0] f;
        f                = '0;
        f[FLAG_CARRY]    = carry;
        f[FLAG_ZERO]     = zero;
        f[FLAG_NEGATIVE] = negative;
        f[FLAG_OVERFLOW] = ovf;
        return f;
    endfunction

    // Expected {flags, result} for one operation, from a plain 33-bit sum.
    function automatic logic [FLAG_BITS+WORD_BITS-1:0] reference_op(input logic sub,
            input logic [WORD_BITS-1:0] a, input logic [WORD_BITS-1:0] b);
        logic [WORD_BITS-1:0] b_eff;
        logic [WORD_BITS:0]   wide;
        logic [FLAG_BITS-1:0] f;
        b_eff = sub ? ~b : b; // A - B is A + ~B + 1.
        wide  = {1'b0, a} + {1'b0, b_eff} + {{WORD_BITS{1'b0}}, sub};
        f = make_flags(wide[WORD_BITS], wide[WORD_BITS-1:0] == '0, wide[WORD_BITS-1],
                       (a[WORD_BITS-1] == b_eff[WORD_BITS-1])
                       && (wide[WORD_BITS-1] != a[WORD_BITS-1]));
        return {f, wide[WORD_BITS-1:0]};
    endfunction

    // The reference must agree with the hand-worked flag cases.
    task automatic check_reference();
        logic [FLAG_BITS+WORD_BITS-1:0] r;
        r = reference_op(1'b0, 32'hFFFF_FFFF, 32'h1);
        compare_flags("reference_all_ones", make_flags(1'b1, 1'b1, 1'b0, 1'b0),
                      r[FLAG_BITS+WORD_BITS-1:WORD_BITS]);
        r = reference_op(1'b0, 32'h7FFF_FFFF, 32'h1);
        compare_flags("reference_add_ovf", make_flags(1'b0, 1'b0, 1'b1, 1'b1),
                      r[FLAG_BITS+WORD_BITS-1:WORD_BITS]);
        r = reference_op(1'b1, 32'h1234_5678, 32'h1234_5678);
        compare_flags("reference_sub_eq", make_flags(1'b1, 1'b1, 1'b0, 1'b0),
                      r[FLAG_BITS+WORD_BITS-1:WORD_BITS]);
        r = reference_op(1'b1, 32'h5, 32'h9);
        compare_flags("reference_sub_neg", make_flags(1'b0, 1'b0, 1'b1, 1'b0),
                      r[FLAG_BITS+WORD_BITS-1:WORD_BITS]);
        r = reference_op(1'b1, 32'h8000_0000, 32'h1);
        compare_flags("reference_sub_ovf", make_flags(1'b1, 1'b0, 1'b0, 1'b1),
                      r[FLAG_BITS+WORD_BITS-1:WORD_BITS]);
    endtask

    task automatic check_reset_state(input string name);
        compare_valid(name, 1'b0, out_valid);
        compare_result(name, '0, result);
        compare_flags(name, '0, flags);
    endtask

    // Presents one operation at the next edge and queues what it must produce.
    task automatic issue_op(input string name, input logic sub,
                            input logic [WORD_BITS-1:0] a, input logic [WORD_BITS-1:0] b);
        logic [FLAG_BITS+WORD_BITS-1:0] expected;
        expected = reference_op(sub, a, b);
        @(posedge clk);
        in_valid  <= 1'b1;
        subtract  <= sub;
        operand_a <= a;
        operand_b <= b;
        exp_result_q.push_back(expected[WORD_BITS-1:0]);
        exp_flags_q.push_back(expected[FLAG_BITS+WORD_BITS-1:WORD_BITS]);
        exp_name_q.push_back(name);
    endtask

    // Idle cycles carry junk operands, which the DUT must ignore.
    task automatic idle_cycles(input int count);
        logic [WORD_BITS-1:0] junk;
        repeat (count) begin
            junk = $random(seed);
            @(posedge clk);
            in_valid  <= 1'b0;
            subtract  <= junk[0];
            operand_a <= junk;
            operand_b <= ~junk;
        end
    endtask

    // Edge counter and timeout.
    always @(posedge clk) begin
        in_valid_seen <= in_valid;         // Value the DUT took at this edge.
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles.", MAX_CYCLES);
            abort_run();
        end
    end

    // Compares at the falling edge, half a period after the outputs settle.
    always @(negedge clk) begin
        if (reset === 1'b0) begin
            compare_valid("valid_timing", in_valid_seen, out_valid); // Exactly one cycle late.
            if (out_valid) begin
                if (exp_result_q.size() == 0) begin
                    $display("out_valid went high with no operation pending.");
                    abort_run();
                end else begin
                    compare_result(exp_name_q[0], exp_result_q[0], result);
                    compare_flags(exp_name_q[0], exp_flags_q[0], flags);
                    void'(exp_result_q.pop_front());
                    void'(exp_flags_q.pop_front());
                    void'(exp_name_q.pop_front());
                    last_result = result;
                    last_flags  = flags;
                end
            end else begin
                compare_result("hold_in_gap", last_result, result); // Outputs stay put.
                compare_flags("hold_in_gap", last_flags, flags);
            end
        end
    end

    initial begin
        seed        = 36934;
        cycle_count = 0;
        last_result = '0;
        last_flags  = '0;
        in_valid_seen <= 1'b0;
        reset         <= 1'b1;
        in_valid      <= 1'b0;
        subtract      <= 1'b0;
        operand_a     <= '0;
        operand_b     <= '0;

        check_reference();

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                reset <= 1'b0; // Taken after this edge, so reset spans five edges.
            end
            @(negedge clk);
            check_reset_state("reset_hold");
        end
        idle_cycles(1);
        @(negedge clk);
        check_reset_state("after_reset");

        // Directed additions over every carry path.
        issue_op("add_zero", 1'b0, 32'h0, 32'h0);
        issue_op("add_all_ones", 1'b0, 32'hFFFF_FFFF, 32'h1);
        for (int k = 0; k < WORD_BITS / BLOCK_BITS; k++) begin
            issue_op("add_block_carry", 1'b0, 32'hF << (4 * k), 32'h1 << (4 * k));
        end
        issue_op("add_group_boundary", 1'b0, 32'h0000_FFFF, 32'h1);
        issue_op("add_high_carry_out", 1'b0, 32'hFFFF_0000, 32'h0001_0000);
        issue_op("add_long_propagate", 1'b0, 32'h0FFF_FFFF, 32'h1);
        issue_op("add_no_carry", 1'b0, 32'hFFFF_FFFE, 32'h1);
        issue_op("add_overflow", 1'b0, 32'h7FFF_FFFF, 32'h1);
        issue_op("add_neg_overflow", 1'b0, 32'h8000_0000, 32'h8000_0000);

        // Directed subtractions.
        issue_op("sub_equal", 1'b1, 32'h1234_5678, 32'h1234_5678);
        issue_op("sub_smaller_larger", 1'b1, 32'h5, 32'h9);
        issue_op("sub_overflow", 1'b1, 32'h8000_0000, 32'h1);
        issue_op("sub_zero_one", 1'b1, 32'h0, 32'h1);
        idle_cycles(2);

        // Back-to-back stream, in_valid never drops.
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rnd_a   = $random(seed);
            rnd_b   = $random(seed);
            rnd_ctl = $random(seed);
            if (rnd_ctl[3:1] == 3'b000) begin
                rnd_b = rnd_a; // Some equal operands to reach the zero flag.
            end
            issue_op("random_stream", rnd_ctl[0], rnd_a, rnd_b);
        end

        // Random idle gaps between operations.
        for (int i = 0; i < GAP_OPS; i++) begin
            rnd_a   = $random(seed);
            rnd_b   = $random(seed);
            rnd_ctl = $random(seed);
            issue_op("random_gaps", rnd_ctl[0], rnd_a, rnd_b);
            idle_cycles(int'(rnd_ctl[15:8]) % (MAX_GAP + 1)); // Zero to MAX_GAP cycles.
        end

        // The last operation is taken at the next edge and reported one cycle later.
        idle_cycles(2);
        @(negedge clk);

        if (exp_result_q.size() != 0) begin
            $display("%0d operations never produced a result.", exp_result_q.size());
            $display("TEST RESULT: FAIL");
            $fatal(1, "Pending operations left at the end of the run.");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- list.f
common/cla_pkg.sv
cla/cla_block4.sv
cla/cla_group16.sv
cla/cla_adder32.sv
src/add_sub_unit.sv
testbench/tb_add_sub_unit.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the add/subtract unit testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail line or lacks the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_add_sub_unit \
    -f list.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed."; exit 1; }

./obj_dir/Vtb_add_sub_unit > sim.log 2>&1 || echo "Simulator returned a non-zero status."
cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation reported a failure."; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation ended without passing."; exit 1; }

echo "Simulation passed."
exit 0
